// ==== hw/bus_consts.svh ====
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// bus widths
`define BUS_ADDR_W   64
`define BUS_DATA_W   64

// on-chip ram, 32-bit words
`define RAM_WORD_W   32
`define RAM_WORDS    1024

// address map
`define RAM_BASE     64'h0000_0000_0000_1000
`define RAM_SIZE     64'd4096                 // bytes, RAM_WORDS * 4
`define KEY_ADDR     64'h0000_0000_0010_0000  // keyboard ascii register
`define UART_ADDR    64'h0000_0000_0010_0008  // console tx byte

// load type codes, bit 2 selects zero extension
`define RT_LB        3'b000
`define RT_LH        3'b001
`define RT_LW        3'b010
`define RT_LD        3'b011
`define RT_LBU       3'b100
`define RT_LHU       3'b101
`define RT_LWU       3'b110

// store type codes
`define WT_SB        3'b000
`define WT_SH        3'b001
`define WT_SW        3'b010
`define WT_SD        3'b011

`define KEY_IRQ_VEC  4'd1  // vector raised on a key press

`endif

// ==== hw/bus_pkg.sv ====
`include "bus_consts.svh"

package bus_pkg;

    // same 3-bit field carries load and store codes
    typedef logic [2:0] access_type_t;

    // one request from the core side, held stable until done
    typedef struct packed {
        logic [`BUS_ADDR_W-1:0] address;
        logic [`BUS_DATA_W-1:0] write_data;
        logic                   read_enable;   // one-cycle pulse
        logic                   write_enable;  // one-cycle pulse
        access_type_t           read_type;
        access_type_t           write_type;
    } bus_req_t;

    // at most one bit set, none set means unmapped
    typedef struct packed {
        logic ram;
        logic key;
        logic uart;
    } region_sel_t;

    // state of the last read, handed to the result formatter
    typedef struct packed {
        region_sel_t            src;        // where the read went
        access_type_t           read_type;
        logic [1:0]             offset;     // byte within the word
        logic [`BUS_DATA_W-1:0] raw;        // ram word(s), unshifted
    } load_capture_t;

    // execute sequencer
    typedef enum logic [1:0] {
        SEQ_IDLE,   // waiting, or doing a first beat
        SEQ_RD_HI,  // ld high word
        SEQ_WR_HI   // sd high word
    } seq_state_t;

endpackage

// ==== hw/bus_decode.sv ====
`timescale 1ns/1ps
`include "bus_consts.svh"

module bus_decode
    import bus_pkg::*;
(
    input  logic [`BUS_ADDR_W-1:0] address,
    output region_sel_t            region
);

    logic in_ram_lo;
    logic in_ram_hi;

    // ram window is [RAM_BASE, RAM_BASE + RAM_SIZE)
    assign in_ram_lo = (address >= `RAM_BASE);
    assign in_ram_hi = (address < (`RAM_BASE + `RAM_SIZE));

    assign region.ram  = in_ram_lo && in_ram_hi;
    assign region.key  = (address == `KEY_ADDR);   // exact match only
    assign region.uart = (address == `UART_ADDR);  // exact match only

    // no bit set falls through as unmapped, execute still completes it

    // windows must never overlap, checked whenever the select moves
    a_region_onehot: assert property (@(region) $onehot0(region))
        else $error("bus_decode: more than one region selected (%b)", region);

endmodule

// ==== hw/mem_execute.sv ====
`timescale 1ns/1ps
`include "bus_consts.svh"

module mem_execute
    import bus_pkg::*;
(
    input  logic          CLOCK_50,
    input  logic          KEY0,
    input  bus_req_t      req,
    input  region_sel_t   region,
    output logic          read_done,
    output logic          write_done,
    output load_capture_t capture,
    output logic          uart_write
);

    localparam int IDX_W = $clog2(`RAM_WORDS);

    logic [`RAM_WORD_W-1:0] ram [0:`RAM_WORDS-1];  // word array, byte lanes by slice

    seq_state_t             state;
    logic [IDX_W-1:0]       word_idx;
    logic [IDX_W-1:0]       next_idx;  // second word of ld / sd
    logic [1:0]             byte_off;
    logic                   busy;
    logic                   rd_beat0;
    logic                   wr_beat0;

    region_sel_t            cap_src;
    access_type_t           cap_type;
    logic [1:0]             cap_off;
    logic [`BUS_DATA_W-1:0] cap_raw;

    // window is 4 KiB aligned, so low address bits index the array directly
    assign word_idx = req.address[IDX_W+1:2];
    assign next_idx = word_idx + 1'b1;  // wraps at top of ram
    assign byte_off = req.address[1:0];

    assign busy = !read_done || !write_done;

    // first beat runs the edge after the enable
    assign rd_beat0 = (state == SEQ_IDLE) && !read_done;
    assign wr_beat0 = (state == SEQ_IDLE) && !write_done;

    // console write goes out on the enable edge itself
    assign uart_write = req.write_enable && region.uart;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= SEQ_IDLE;
            read_done  <= 1'b1;  // idle bus reports done
            write_done <= 1'b1;
            cap_src    <= '0;    // unmapped, reads as zero
            cap_type   <= '0;
            cap_off    <= '0;
        end else begin
            // E0: drop done and remember what the read was
            if (req.read_enable) begin
                read_done <= 1'b0;
                cap_src   <= region;
                cap_type  <= req.read_type;
                cap_off   <= byte_off;
            end
            if (req.write_enable) begin
                write_done <= 1'b0;
            end

            case (state)
                SEQ_IDLE: begin
                    if (rd_beat0) begin
                        if (cap_src.ram && cap_type == `RT_LD) begin
                            state <= SEQ_RD_HI;  // one more word to fetch
                        end else begin
                            read_done <= 1'b1;   // key, unmapped, sub-double ram
                        end
                    end
                    if (wr_beat0) begin
                        if (region.ram && req.write_type == `WT_SD) begin
                            state <= SEQ_WR_HI;
                        end else begin
                            write_done <= 1'b1;  // console write also ends here
                        end
                    end
                end
                SEQ_RD_HI: begin
                    read_done <= 1'b1;
                    state     <= SEQ_IDLE;
                end
                SEQ_WR_HI: begin
                    write_done <= 1'b1;
                    state      <= SEQ_IDLE;
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // ram port and load data, no reset
    always_ff @(posedge CLOCK_50) begin
        if (rd_beat0 && cap_src.ram) begin
            // low word, upper half cleared unless ld fills it next
            cap_raw <= {{(`BUS_DATA_W-`RAM_WORD_W){1'b0}}, ram[word_idx]};
        end
        if (state == SEQ_RD_HI) begin
            cap_raw[`BUS_DATA_W-1 -: `RAM_WORD_W] <= ram[next_idx];
        end

        if (wr_beat0 && region.ram) begin
            case (req.write_type)
                `WT_SB: ram[word_idx][{byte_off, 3'b000} +: 8] <= req.write_data[7:0];
                `WT_SH: ram[word_idx][{byte_off[1], 4'b0000} +: 16] <= req.write_data[15:0];
                `WT_SW,
                `WT_SD: ram[word_idx] <= req.write_data[`RAM_WORD_W-1:0];  // sd low word
                default: ;  // reserved codes store nothing
            endcase
        end
        if (state == SEQ_WR_HI) begin
            ram[next_idx] <= req.write_data[`BUS_DATA_W-1 -: `RAM_WORD_W];
        end
    end

    assign capture = '{src: cap_src, read_type: cap_type, offset: cap_off, raw: cap_raw};

    // single access in flight, the core waits for both done flags
    a_no_enable_busy: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (req.read_enable || req.write_enable) |-> (!busy && state == SEQ_IDLE))
        else $error("mem_execute: enable while an access is still in flight");

    // halfword lanes are 0 or 2 only
    a_sh_even: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (req.write_enable && region.ram && req.write_type == `WT_SH) |-> !byte_off[0])
        else $error("mem_execute: sh at odd offset %0d", byte_off);

    // whole-word ram accesses are word aligned
    a_word_aligned: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        ((req.write_enable && region.ram && req.write_type == `WT_SW) ||
         (req.read_enable && region.ram && req.read_type == `RT_LW)) |-> (byte_off == 2'b00))
        else $error("mem_execute: sw/lw at offset %0d", byte_off);

endmodule

// ==== hw/load_result.sv ====
`timescale 1ns/1ps
`include "bus_consts.svh"

module load_result
    import bus_pkg::*;
(
    input  load_capture_t          capture,
    input  logic [7:0]             key_ascii,
    output logic [`BUS_DATA_W-1:0] read_data
);

    logic [`BUS_DATA_W-1:0] shifted;

    // requested byte lands at bit 0
    assign shifted = capture.raw >> {capture.offset, 3'b000};

    always_comb begin
        read_data = '0;  // unmapped and uart reads give zero
        if (capture.src.ram) begin
            case (capture.read_type)
                `RT_LB: begin
                    read_data = {{(`BUS_DATA_W-8){shifted[7]}}, shifted[7:0]};
                end
                `RT_LH: begin
                    read_data = {{(`BUS_DATA_W-16){shifted[15]}}, shifted[15:0]};
                end
                `RT_LW: begin
                    read_data = {{(`BUS_DATA_W-32){shifted[31]}}, shifted[31:0]};
                end
                `RT_LBU: read_data = {{(`BUS_DATA_W-8){1'b0}}, shifted[7:0]};
                `RT_LHU: read_data = {{(`BUS_DATA_W-16){1'b0}}, shifted[15:0]};
                `RT_LWU: read_data = {{(`BUS_DATA_W-32){1'b0}}, shifted[31:0]};
                `RT_LD:  read_data = capture.raw;  // both words, offset is zero
                default: read_data = '0;           // 3'b111 unused
            endcase
        end else if (capture.src.key) begin
            // key register is a plain byte for any load type
            read_data = {{(`BUS_DATA_W-8){1'b0}}, key_ascii};
        end
    end

endmodule

// ==== hw/console_io.sv ====
`timescale 1ns/1ps
`include "bus_consts.svh"

module console_io (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic [7:0] ascii,
    input  logic       key_pressed,
    input  logic       interrupt_ack,
    input  logic       uart_write,
    input  logic [7:0] write_byte,
    output logic [7:0] key_ascii,
    output logic [3:0] interrupt_vector,
    output logic       uart_strobe,
    output logic [7:0] uart_data
);

    logic key_pressed_d;  // last cycle's level
    logic press_edge;

    // new press with a printable code, ascii zero is a non-character key
    assign press_edge = key_pressed && !key_pressed_d && (ascii != 8'd0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_pressed_d    <= 1'b0;
            key_ascii        <= 8'd0;
            interrupt_vector <= 4'd0;
            uart_strobe      <= 1'b0;
        end else begin
            key_pressed_d <= key_pressed;
            uart_strobe   <= uart_write;  // high the one cycle after E0

            // ack first, so a press in the same cycle still raises the vector
            if (interrupt_ack) begin
                interrupt_vector <= 4'd0;
            end
            if (press_edge) begin
                key_ascii        <= ascii;  // held until the next press
                interrupt_vector <= `KEY_IRQ_VEC;
            end
        end
    end

    // tx byte rides with the strobe
    always_ff @(posedge CLOCK_50) begin
        if (uart_write) begin
            uart_data <= write_byte;
        end
    end

    // strobe comes from a one-cycle enable, so it never stretches
    a_strobe_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_strobe |=> !uart_strobe)
        else $error("console_io: uart_strobe held for more than one cycle");

endmodule

// ==== hw/bus_fabric.sv ====
`timescale 1ns/1ps
`include "bus_consts.svh"

module bus_fabric
    import bus_pkg::*;
(
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  bus_req_t               req,
    input  logic [7:0]             ascii,
    input  logic                   key_pressed,
    input  logic                   interrupt_ack,
    output logic [`BUS_DATA_W-1:0] read_data,
    output logic                   read_done,
    output logic                   write_done,
    output logic [3:0]             interrupt_vector,
    output logic                   uart_strobe,
    output logic [7:0]             uart_data
);

    region_sel_t   region;     // decode to execute
    load_capture_t capture;    // execute to result
    logic          uart_write; // console write request
    logic [7:0]    key_ascii;  // latched key byte

    // address decode
    bus_decode i_decode (
        .address (req.address),
        .region  (region)
    );

    // ram and done sequencing
    mem_execute i_execute (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req        (req),
        .region     (region),
        .read_done  (read_done),
        .write_done (write_done),
        .capture    (capture),
        .uart_write (uart_write)
    );

    // keyboard and console side
    console_io i_console (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .ascii            (ascii),
        .key_pressed      (key_pressed),
        .interrupt_ack    (interrupt_ack),
        .uart_write       (uart_write),
        .write_byte       (req.write_data[7:0]),  // console takes the low byte
        .key_ascii        (key_ascii),
        .interrupt_vector (interrupt_vector),
        .uart_strobe      (uart_strobe),
        .uart_data        (uart_data)
    );

    // load formatting
    load_result i_result (
        .capture   (capture),
        .key_ascii (key_ascii),
        .read_data (read_data)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic CLOCK_50,
    output logic KEY0
);

    // 8 ns period
    initial begin
        CLOCK_50 = 1'b0;
        forever #4 CLOCK_50 = ~CLOCK_50;
    end

    // reset held through two rising edges, released between edges
    initial begin
        KEY0 = 1'b0;
        repeat (2) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        KEY0 = 1'b1;
    end

endmodule

// ==== verif/tb_bus_fabric.sv ====
`timescale 1ns/1ps
`include "bus_consts.svh"

module tb_bus_fabric
    import bus_pkg::*;
();

    localparam int WAIT_LIMIT = 16;  // cycles before a wait gives up

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_PRESS, OP_ACK} op_t;

    // one row of the stimulus table
    typedef struct packed {
        op_t          op;
        access_type_t typ;       // load or store code
        logic [63:0]  addr;
        logic [63:0]  wdata;     // store data, or ascii for a press
        logic [63:0]  exp_data;  // load result, or vector after press / ack
    } step_t;

    logic        CLOCK_50;
    logic        KEY0;
    bus_req_t    req;
    logic [7:0]  ascii;
    logic        key_pressed;
    logic        interrupt_ack;
    logic [63:0] read_data;
    logic        read_done;
    logic        write_done;
    logic [3:0]  interrupt_vector;
    logic        uart_strobe;
    logic [7:0]  uart_data;

    step_t       steps[$];
    logic [31:0] lfsr_state;
    logic [7:0]  shadow [0:4095];  // byte image of the ram window
    logic [7:0]  key_model;        // last nonzero ascii pressed
    logic [3:0]  vec_model;
    int          mismatches;
    int          timeouts;

    tb_clock_gen i_clk (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    bus_fabric i_dut (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .req              (req),
        .ascii            (ascii),
        .key_pressed      (key_pressed),
        .interrupt_ack    (interrupt_ack),
        .read_data        (read_data),
        .read_done        (read_done),
        .write_done       (write_done),
        .interrupt_vector (interrupt_vector),
        .uart_strobe      (uart_strobe),
        .uart_data        (uart_data)
    );

    // x^32 + x^22 + x^2 + x + 1, shift left, feedback into bit 0
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic in_ram(input logic [63:0] addr);
        return (addr >= `RAM_BASE) && (addr < `RAM_BASE + `RAM_SIZE);
    endfunction

    // little-endian bytes from the image, extended per the load code
    function automatic logic [63:0] expected_load(input access_type_t typ,
                                                  input logic [63:0] addr);
        logic [63:0] v;
        int          nbytes;
        int          off;
        int          i;
        v = '0;
        if (in_ram(addr)) begin
            off    = addr - `RAM_BASE;
            nbytes = 1 << typ[1:0];  // 1, 2, 4 or 8 bytes
            for (i = 0; i < nbytes; i++) begin
                v[8*i +: 8] = shadow[off + i];
            end
            if (!typ[2] && nbytes < 8 && v[8*nbytes-1]) begin
                v = v | (~64'd0 << (8 * nbytes));  // sign fill
            end
        end else if (addr == `KEY_ADDR) begin
            v = {56'd0, key_model};  // any load type, zero extended
        end
        return v;
    endfunction

    task automatic store_model(input access_type_t typ, input logic [63:0] addr,
                               input logic [63:0] data);
        int nbytes;
        int off;
        int i;
        if (in_ram(addr)) begin
            off    = addr - `RAM_BASE;
            nbytes = 1 << typ[1:0];
            for (i = 0; i < nbytes; i++) begin
                shadow[off + i] = data[8*i +: 8];
            end
        end
        // console and unmapped stores leave the image alone
    endtask

    // builds a row and its expected value from the model
    task automatic add_step(input op_t op, input access_type_t typ,
                            input logic [63:0] addr, input logic [63:0] wdata);
        step_t s;
        s = '{op: op, typ: typ, addr: addr, wdata: wdata, exp_data: '0};
        case (op)
            OP_WR: store_model(typ, addr, wdata);
            OP_RD: s.exp_data = expected_load(typ, addr);
            OP_PRESS: begin
                if (wdata[7:0] != 8'd0) begin
                    key_model = wdata[7:0];
                    vec_model = 4'd1;
                end
                s.exp_data = vec_model;  // ascii zero leaves it as it was
            end
            OP_ACK: begin
                vec_model  = 4'd0;
                s.exp_data = vec_model;
            end
        endcase
        steps.push_back(s);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // one bus access, entered and left just after a falling edge
    task automatic run_access(input step_t s);
        logic is_rd;
        logic done;
        logic first_strobe;
        logic [7:0] first_byte;
        int   cycles;
        int   strobes;
        int   exp_lat;
        is_rd = (s.op == OP_RD);
        req.address      = s.addr;
        req.write_data   = s.wdata;
        req.read_type    = s.typ;
        req.write_type   = s.typ;
        req.read_enable  = is_rd;
        req.write_enable = !is_rd;
        @(negedge CLOCK_50);  // E0 behind us
        first_strobe = uart_strobe;
        first_byte   = uart_data;
        strobes      = uart_strobe;
        done         = is_rd ? read_done : write_done;
        if (is_rd) check("read_done", done, 1'b0);
        else check("write_done", done, 1'b0);
        req.read_enable  = 1'b0;
        req.write_enable = 1'b0;
        cycles = 0;
        while (!done && cycles < WAIT_LIMIT) begin
            @(negedge CLOCK_50);
            cycles++;
            strobes += uart_strobe;
            done = is_rd ? read_done : write_done;
        end
        if (!done) begin
            timeouts++;
            $display("Timeout at %0t ns: access to address %0h never finished", $time, s.addr);
        end else begin
            // double ram accesses take a second beat
            exp_lat = (in_ram(s.addr) && s.typ[1:0] == 2'b11) ? 2 : 1;
            check("done latency", cycles, exp_lat);
            if (is_rd) begin
                check("read_data", read_data, s.exp_data);
                check("uart_strobe count", strobes, 0);
            end else if (s.addr == `UART_ADDR) begin
                check("uart_strobe", first_strobe, 1'b1);  // cycle right after E0
                check("uart_strobe count", strobes, 1);
                check("uart_data", first_byte, s.wdata[7:0]);
            end else begin
                check("uart_strobe count", strobes, 0);
            end
        end
    endtask

    task automatic run_press(input step_t s);
        ascii       = s.wdata[7:0];
        key_pressed = 1'b1;
        @(negedge CLOCK_50);
        check("interrupt_vector", interrupt_vector, s.exp_data);
        key_pressed = 1'b0;
        @(negedge CLOCK_50);
        check("interrupt_vector", interrupt_vector, s.exp_data);  // held after release
    endtask

    task automatic run_ack(input step_t s);
        interrupt_ack = 1'b1;
        @(negedge CLOCK_50);
        check("interrupt_vector", interrupt_vector, s.exp_data);
        interrupt_ack = 1'b0;
        @(negedge CLOCK_50);
    endtask

    initial begin
        logic [63:0] d;
        int          k;
        int          n;
        req           = '0;
        ascii         = 8'd0;
        key_pressed   = 1'b0;
        interrupt_ack = 1'b0;
        lfsr_state    = 32'h3be6;
        key_model     = 8'd0;
        vec_model     = 4'd0;
        mismatches    = 0;
        timeouts      = 0;

        // word and double
        d = rand_bits(64);
        d[31] = 1'b1;  // negative word
        add_step(OP_WR, `WT_SW, `RAM_BASE + 64'h0, d);
        d = rand_bits(64);
        d[31] = 1'b0;
        add_step(OP_WR, `WT_SW, `RAM_BASE + 64'h4, d);
        add_step(OP_RD, `RT_LW,  `RAM_BASE + 64'h0, '0);
        add_step(OP_RD, `RT_LWU, `RAM_BASE + 64'h0, '0);
        add_step(OP_RD, `RT_LW,  `RAM_BASE + 64'h4, '0);
        add_step(OP_RD, `RT_LWU, `RAM_BASE + 64'h4, '0);
        d = rand_bits(64);
        d[63] = 1'b1;  // high word negative too
        add_step(OP_WR, `WT_SD, `RAM_BASE + 64'h10, d);
        add_step(OP_RD, `RT_LD,  `RAM_BASE + 64'h10, '0);
        add_step(OP_RD, `RT_LW,  `RAM_BASE + 64'h14, '0);
        add_step(OP_RD, `RT_LWU, `RAM_BASE + 64'h14, '0);

        // byte lanes, then halves
        for (k = 0; k < 4; k++) begin
            d = rand_bits(64);
            if (k == 1) d[7] = 1'b1;
            add_step(OP_WR, `WT_SB, `RAM_BASE + 64'h20 + k, d);
        end
        d = rand_bits(64);
        d[15] = 1'b1;
        add_step(OP_WR, `WT_SH, `RAM_BASE + 64'h30, d);
        d = rand_bits(64);
        d[15] = 1'b0;
        add_step(OP_WR, `WT_SH, `RAM_BASE + 64'h32, d);
        for (k = 0; k < 4; k++) begin
            add_step(OP_RD, `RT_LB,  `RAM_BASE + 64'h20 + k, '0);
            add_step(OP_RD, `RT_LBU, `RAM_BASE + 64'h20 + k, '0);
        end
        for (k = 0; k < 4; k += 2) begin
            add_step(OP_RD, `RT_LH,  `RAM_BASE + 64'h30 + k, '0);
            add_step(OP_RD, `RT_LHU, `RAM_BASE + 64'h30 + k, '0);
            add_step(OP_RD, `RT_LH,  `RAM_BASE + 64'h20 + k, '0);
            add_step(OP_RD, `RT_LHU, `RAM_BASE + 64'h20 + k, '0);
        end
        add_step(OP_RD, `RT_LW, `RAM_BASE + 64'h20, '0);  // merged lanes
        add_step(OP_RD, `RT_LW, `RAM_BASE + 64'h30, '0);

        // keyboard, high ascii bit shows zero extension
        add_step(OP_PRESS, '0, '0, 64'hc1);
        add_step(OP_RD, `RT_LB, `KEY_ADDR, '0);
        add_step(OP_ACK, '0, '0, '0);
        add_step(OP_PRESS, '0, '0, 64'h0);  // no interrupt
        add_step(OP_RD, `RT_LD, `KEY_ADDR, '0);

        // console
        add_step(OP_WR, `WT_SB, `UART_ADDR, rand_bits(64));
        add_step(OP_WR, `WT_SW, `UART_ADDR, rand_bits(64));

        // unmapped, ram must stay untouched
        add_step(OP_RD, `RT_LW, 64'h20_0000, '0);
        add_step(OP_RD, `RT_LD, `RAM_BASE + `RAM_SIZE, '0);  // just past the window
        add_step(OP_WR, `WT_SW, 64'h20_0000, rand_bits(64));
        add_step(OP_WR, `WT_SD, 64'h10, rand_bits(64));  // below the window, same low bits as ram + 0x10
        add_step(OP_RD, `RT_LW, `RAM_BASE + 64'h0, '0);
        add_step(OP_RD, `RT_LD, `RAM_BASE + 64'h10, '0);

        // reset release
        n = 0;
        while (KEY0 !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (KEY0 !== 1'b1) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end
        @(negedge CLOCK_50);
        check("read_done", read_done, 1'b1);
        check("write_done", write_done, 1'b1);
        check("interrupt_vector", interrupt_vector, 4'd0);
        check("uart_strobe", uart_strobe, 1'b0);

        foreach (steps[i]) begin
            case (steps[i].op)
                OP_WR, OP_RD: run_access(steps[i]);
                OP_PRESS:     run_press(steps[i]);
                OP_ACK:       run_ack(steps[i]);
            endcase
        end

        $display("errors: %0d mismatches, %0d timeouts over %0d steps",
                 mismatches, timeouts, steps.size());
        if (mismatches == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== bus_fabric.f ====
+incdir+hw
hw/bus_pkg.sv
hw/bus_decode.sv
hw/mem_execute.sv
hw/load_result.sv
hw/console_io.sv
hw/bus_fabric.sv
verif/tb_clock_gen.sv
verif/tb_bus_fabric.sv
